// File: files.f
+incdir+rtl
rtl/cpri_frame_pkg.sv
rtl/dr_core_pkg.sv
rtl/pipe_stage.sv
rtl/rx_unpack.sv
rtl/rbg_ctrl_fsm.sv
rtl/rbg_counter.sv
rtl/power_accum.sv
rtl/tx_repack.sv
rtl/pusch_dr_top.sv
testbench/tb_pusch_dr.sv

// File: Bender.yml
package:
  name: pusch_dr

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpri_frame_pkg.sv
      - rtl/dr_core_pkg.sv
      - rtl/pipe_stage.sv
      - rtl/rx_unpack.sv
      - rtl/rbg_ctrl_fsm.sv
      - rtl/rbg_counter.sv
      - rtl/power_accum.sv
      - rtl/tx_repack.sv
      - rtl/pusch_dr_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_pusch_dr.sv

// File: testbench/tb_pusch_dr.sv
// Testbench for the PUSCH power front end
// random packets with random IQ, valid gaps and tx back-pressure
// queue model of the expected frames, word checker, watchdog
`timescale 1ns/100ps
`default_nettype none

`include "pusch_dr_config.svh"

module tb_pusch_dr;

    localparam int          CLK_PERIOD = 20;
    localparam int          N_TESTS    = 12;
    localparam int          N_PKTS     = 3;         // packets per test
    localparam int          MAX_RE     = 40;
    localparam int          FRAME_W    = 1 + `PUSCH_ANT;
    // worst case per packet: header and 40 RE beats in, 10 frames out
    localparam int          PKT_ITEMS  = 1 + MAX_RE + (MAX_RE / `PUSCH_RBG_LEN_0) * FRAME_W;
    localparam int          WATCHDOG   = N_TESTS * N_PKTS * PKT_ITEMS * 20 + 2000;
    localparam logic [31:0] SEED       = 32'ha823a478;

    logic                     i_clk = 1'b0;
    logic                     i_rst_n;
    cpri_frame_pkg::rx_beat_t i_rx_beat;
    logic                     i_rx_valid;
    logic                     o_rx_ready;
    cpri_frame_pkg::tx_word_t o_tx_word;
    logic                     o_tx_valid;
    logic                     i_tx_ready;
    logic [1:0]               i_aiu_idx;
    dr_core_pkg::rbg_size_e   i_rbg_size;

    logic [63:0] exp_q[$];                          // expected tx words in order
    int          errors    = 0;
    int          checks    = 0;
    int          got_words = 0;

    pusch_dr_top pusch_dr_top_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rx_beat (i_rx_beat),
        .i_rx_valid(i_rx_valid),
        .o_rx_ready(o_rx_ready),
        .o_tx_word (o_tx_word),
        .o_tx_valid(o_tx_valid),
        .i_tx_ready(i_tx_ready),
        .i_aiu_idx (i_aiu_idx),
        .i_rbg_size(i_rbg_size)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // ----------------------------------------------------------
    // helpers
    // ----------------------------------------------------------
    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // one clock, new tx ready on the falling edge
    task automatic next_cycle();
        @(negedge i_clk);
        i_tx_ready = ($urandom % 4) != 0;           // roughly one stall in four
    endtask

    // I*I + Q*Q of one antenna, I in the upper 16 bits
    function automatic longint re_power(input logic [31:0] iq);
        longint i_val;
        longint q_val;
        i_val = longint'($signed(iq[31:16]));
        q_val = longint'($signed(iq[15:0]));
        return i_val * i_val + q_val * q_val;
    endfunction

    task automatic send_beat(input cpri_frame_pkg::rx_beat_t beat);
        logic accepted;
        repeat ($urandom % 3) next_cycle();         // random valid gap
        i_rx_beat  = beat;
        i_rx_valid = 1'b1;
        do begin
            @(posedge i_clk);
            accepted = o_rx_ready;
            next_cycle();
        end while (!accepted);
        i_rx_valid = 1'b0;
    endtask

    // drives one packet and queues the frames it should produce
    task automatic send_packet(input int n_re, input int rbg_len, inout int frames);
        cpri_frame_pkg::rx_beat_t beat;
        logic [3:0] pkg_type;
        logic       cell_idx;
        logic [6:0] slot_idx;
        logic [3:0] symb_idx;
        logic [7:0] fft_agc;
        logic [3:0] rbg_idx;
        longint     pwr [`PUSCH_ANT];
        pkg_type = 4'($urandom);
        cell_idx = 1'($urandom);
        slot_idx = 7'($urandom);
        symb_idx = 4'($urandom);
        fft_agc  = 8'($urandom);
        rbg_idx  = '0;
        beat     = '0;
        beat.lane[0] = {pkg_type, cell_idx, slot_idx, symb_idx, fft_agc, 40'd0};
        beat.sop     = 1'b1;
        send_beat(beat);
        foreach (pwr[a]) pwr[a] = 0;
        for (int r = 0; r < n_re; r++) begin
            beat = '0;
            for (int k = 0; k < `PUSCH_LANE; k++) begin
                beat.lane[k] = {$urandom, $urandom};
                pwr[2*k]   += re_power(beat.lane[k][31:0]);     // low half
                pwr[2*k+1] += re_power(beat.lane[k][63:32]);    // high half
            end
            beat.eop = (r == n_re - 1);
            send_beat(beat);
            if ((r + 1) % rbg_len == 0 || beat.eop) begin
                exp_q.push_back({i_aiu_idx, pkg_type, cell_idx, slot_idx, symb_idx,
                                 rbg_idx, fft_agc, 34'd0});
                foreach (pwr[a]) begin
                    exp_q.push_back(64'(pwr[a]));
                    pwr[a] = 0;
                end
                rbg_idx++;
                frames++;
            end
        end
    endtask

    // ----------------------------------------------------------
    // output monitor
    // ----------------------------------------------------------
    always @(posedge i_clk) begin
        if (i_rst_n && o_tx_valid && i_tx_ready) begin
            got_words++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("tx word 0x%h arrived while no frame was pending", o_tx_word);
            end else begin
                check("o_tx_word", o_tx_word, exp_q.pop_front());
            end
        end
    end

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial begin
        int size_code;
        int rbg_len;
        int frames;
        int errs_before;
        int words_before;
        void'($urandom(SEED));
        i_rst_n    = 1'b0;
        i_rx_beat  = '0;
        i_rx_valid = 1'b0;
        i_tx_ready = 1'b0;
        i_aiu_idx  = 2'd0;
        i_rbg_size = dr_core_pkg::RBG_4;
        repeat (8) begin
            @(posedge i_clk);
            check("o_tx_valid", 64'(o_tx_valid), 64'd0);
        end
        @(negedge i_clk);
        i_rst_n = 1'b1;
        repeat (4) begin                            // idle, nothing supplied yet
            next_cycle();
            check("o_tx_valid", 64'(o_tx_valid), 64'd0);
        end
        for (int t = 0; t < N_TESTS; t++) begin
            errs_before  = errors;
            words_before = got_words;
            frames       = 0;
            size_code    = (t < 4) ? t : int'($urandom % 4);    // every code at least once
            rbg_len      = (size_code == 0) ? `PUSCH_RBG_LEN_0 :
                           (size_code == 1) ? `PUSCH_RBG_LEN_1 : `PUSCH_RBG_LEN_2;
            i_rbg_size   = dr_core_pkg::rbg_size_e'(size_code);
            i_aiu_idx    = 2'($urandom);
            for (int p = 0; p < N_PKTS; p++) begin
                send_packet(1 + int'($urandom % MAX_RE), rbg_len, frames);
            end
            while (exp_q.size() != 0) next_cycle();
            repeat (2 * FRAME_W) next_cycle();      // catch stray extra words
            check("frame words", 64'(got_words - words_before), 64'(frames * FRAME_W));
            $display("test %0d: rbg_size %0d, %0d frames, %s", t, size_code, frames,
                     (errors == errs_before) ? "ok" : "errors");
        end
        $display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // ----------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------
    initial begin
        repeat (WATCHDOG) @(posedge i_clk);
        $display("timeout after %0d cycles, the DUT stopped moving data", WATCHDOG);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/pusch_dr_top.sv
// PUSCH power front end, top level
// rx slice, unpacker, control FSM, counters, accumulators,
// frame serializer and tx slice
`timescale 1ns/100ps
`default_nettype none

`include "pusch_dr_config.svh"

module pusch_dr_top (
    input  wire logic                     i_clk,
    input  wire logic                     i_rst_n,

    input  wire cpri_frame_pkg::rx_beat_t i_rx_beat,
    input  wire logic                     i_rx_valid,
    output logic                          o_rx_ready,

    output cpri_frame_pkg::tx_word_t      o_tx_word,
    output logic                          o_tx_valid,
    input  wire logic                     i_tx_ready,

    input  wire logic [1:0]               i_aiu_idx,   // AIU index 0-3
    input  wire dr_core_pkg::rbg_size_e   i_rbg_size   // static within a packet
);

    // ----------------------------------------------------------
    // internal nets
    // ----------------------------------------------------------
    cpri_frame_pkg::rx_beat_t        rx_beat;
    logic                            rx_valid, rx_ready;
    cpri_frame_pkg::rx_hdr_t         hdr;
    logic                            hdr_valid;
    dr_core_pkg::ant_iq_t            re;
    logic                            re_valid, re_eop, take;
    logic                            accum_en, accum_clr, cnt_step, cnt_rst;
    logic                            flush_valid, flush_done, rbg_last;
    logic [`PUSCH_RBG_IDX_W-1:0]     rbg_idx;
    dr_core_pkg::pwr_vec_t           pwr;
    cpri_frame_pkg::tx_word_t        tx_word;
    logic                            tx_valid, tx_ready;

    pipe_stage #(.T(cpri_frame_pkg::rx_beat_t)) rx_stage_i (
        .i_clk  (i_clk),      .i_rst_n(i_rst_n),
        .i_data (i_rx_beat),  .i_valid(i_rx_valid), .o_ready(o_rx_ready),
        .o_data (rx_beat),    .o_valid(rx_valid),   .i_ready(rx_ready));

    rx_unpack rx_unpack_i (
        .i_clk (i_clk),  .i_rst_n(i_rst_n),
        .i_beat(rx_beat), .i_valid(rx_valid), .o_ready(rx_ready), .i_take(take),
        .o_hdr (hdr), .o_hdr_valid(hdr_valid),
        .o_re  (re),  .o_re_valid(re_valid), .o_re_eop(re_eop));

    rbg_ctrl_fsm rbg_ctrl_fsm_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_hdr_valid(hdr_valid), .i_re_valid(re_valid), .i_re_eop(re_eop),
        .i_rbg_last(rbg_last), .i_flush_done(flush_done), .o_take(take),
        .o_accum_en(accum_en), .o_accum_clr(accum_clr),
        .o_cnt_step(cnt_step), .o_cnt_rst(cnt_rst), .o_flush_valid(flush_valid));

    rbg_counter rbg_counter_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_rbg_size(i_rbg_size),
        .i_step(cnt_step), .i_rst_cnt(cnt_rst),
        .o_rbg_last(rbg_last), .o_rbg_idx(rbg_idx));

    power_accum power_accum_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_re(re),
        .i_en(accum_en), .i_clr(accum_clr), .o_pwr(pwr));

    tx_repack tx_repack_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_flush_valid(flush_valid),
        .i_hdr(hdr), .i_aiu_idx(i_aiu_idx), .i_rbg_idx(rbg_idx), .i_pwr(pwr),
        .o_flush_done(flush_done),
        .o_word(tx_word), .o_valid(tx_valid), .i_ready(tx_ready));

    pipe_stage #(.T(cpri_frame_pkg::tx_word_t)) tx_stage_i (
        .i_clk  (i_clk),     .i_rst_n(i_rst_n),
        .i_data (tx_word),   .i_valid(tx_valid),   .o_ready(tx_ready),
        .o_data (o_tx_word), .o_valid(o_tx_valid), .i_ready(i_tx_ready));

endmodule

`default_nettype wire

// File: rtl/tx_repack.sv
// Tx frame serializer
// captures header fields and power sums at flush start,
// then sends the header word and one power word per antenna
`timescale 1ns/100ps
`default_nettype none

`include "pusch_dr_config.svh"

module tx_repack (
    input  wire logic                         i_clk,
    input  wire logic                         i_rst_n,
    input  wire logic                         i_flush_valid,
    input  wire cpri_frame_pkg::rx_hdr_t      i_hdr,
    input  wire logic [1:0]                   i_aiu_idx,
    input  wire logic [`PUSCH_RBG_IDX_W-1:0]  i_rbg_idx,
    input  wire dr_core_pkg::pwr_vec_t        i_pwr,
    output logic                              o_flush_done,
    output cpri_frame_pkg::tx_word_t          o_word,
    output logic                              o_valid,
    input  wire logic                         i_ready
);

    localparam int IDX_W = $clog2(`PUSCH_ANT + 1);

    logic                    busy_q;
    logic [IDX_W-1:0]        idx_q;             // 0 is the header word
    cpri_frame_pkg::tx_hdr_t hdr_q;
    dr_core_pkg::pwr_vec_t   pwr_q;
    logic                    last_word;

    assign o_valid      = busy_q;
    assign last_word    = (idx_q == IDX_W'(`PUSCH_ANT));
    assign o_flush_done = busy_q & i_ready & last_word;
    assign o_word       = (idx_q == '0) ? hdr_q :
                          {{(`PUSCH_WORD_W-`PUSCH_PWR_W){1'b0}}, pwr_q[idx_q - IDX_W'(1)]};

    // ----------------------------------------------------------
    // word sequencing
    // ----------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (!busy_q) begin
            busy_q <= i_flush_valid;
            idx_q  <= '0;
        end else if (i_ready) begin
            busy_q <= ~last_word;
            idx_q  <= idx_q + IDX_W'(1);
        end
    end

    always_ff @(posedge i_clk) begin
        if (!busy_q && i_flush_valid) begin
            pwr_q <= i_pwr;
            hdr_q <= '{aiu_idx:  i_aiu_idx,
                       pkg_type: i_hdr.pkg_type,
                       cell_idx: i_hdr.cell_idx,
                       slot_idx: i_hdr.slot_idx,
                       symb_idx: i_hdr.symb_idx,
                       rbg_idx:  i_rbg_idx,
                       fft_agc:  i_hdr.fft_agc,
                       pad:      '0};
        end
    end

endmodule

`default_nettype wire

// File: rtl/power_accum.sv
// Per-antenna power accumulators
// I*I + Q*Q of each RE summed into a 40-bit total
// clear together with enable loads the new RE only
`timescale 1ns/100ps
`default_nettype none

`include "pusch_dr_config.svh"

module power_accum (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire dr_core_pkg::ant_iq_t i_re,
    input  wire logic                 i_en,
    input  wire logic                 i_clr,
    output dr_core_pkg::pwr_vec_t     o_pwr
);

    logic signed [2*`PUSCH_IQ_W-1:0] i_sq [`PUSCH_ANT];
    logic signed [2*`PUSCH_IQ_W-1:0] q_sq [`PUSCH_ANT];
    logic        [2*`PUSCH_IQ_W:0]   re_pwr [`PUSCH_ANT];  // one bit of headroom

    always_comb begin
        for (int a = 0; a < `PUSCH_ANT; a++) begin
            i_sq[a]   = $signed(i_re[a].i) * $signed(i_re[a].i);
            q_sq[a]   = $signed(i_re[a].q) * $signed(i_re[a].q);
            // squares are never negative, so treat them as unsigned
            re_pwr[a] = {1'b0, i_sq[a]} + {1'b0, q_sq[a]};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pwr <= '0;
        end else begin
            for (int a = 0; a < `PUSCH_ANT; a++) begin
                if (i_clr) begin
                    o_pwr[a] <= i_en ? `PUSCH_PWR_W'(re_pwr[a]) : '0;
                end else if (i_en) begin
                    o_pwr[a] <= o_pwr[a] + `PUSCH_PWR_W'(re_pwr[a]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rbg_counter.sv
// RE and RBG index counters
// group length decoded from the RBG size code
`timescale 1ns/100ps
`default_nettype none

`include "pusch_dr_config.svh"

module rbg_counter (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire dr_core_pkg::rbg_size_e  i_rbg_size,
    input  wire logic                    i_step,
    input  wire logic                    i_rst_cnt,
    output logic                         o_rbg_last,
    output logic [`PUSCH_RBG_IDX_W-1:0]  o_rbg_idx
);

    logic [4:0] rbg_len;
    logic [3:0] re_cnt;                         // RE position within the group

    always_comb begin
        case (i_rbg_size)
            dr_core_pkg::RBG_4: rbg_len = 5'(`PUSCH_RBG_LEN_0);
            dr_core_pkg::RBG_8: rbg_len = 5'(`PUSCH_RBG_LEN_1);
            default:            rbg_len = 5'(`PUSCH_RBG_LEN_2);
        endcase
    end

    assign o_rbg_last = ({1'b0, re_cnt} == rbg_len - 5'd1);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            re_cnt    <= '0;
            o_rbg_idx <= '0;
        end else if (i_rst_cnt) begin
            re_cnt    <= '0;
            o_rbg_idx <= '0;
        end else if (i_step) begin
            re_cnt    <= o_rbg_last ? 4'd0 : re_cnt + 4'd1;
            o_rbg_idx <= o_rbg_idx + {{(`PUSCH_RBG_IDX_W-1){1'b0}}, o_rbg_last};
        end
    end

endmodule

`default_nettype wire

// File: rtl/rbg_ctrl_fsm.sv
// RBG control FSM
// IDLE waits for a packet header, ACCUM takes REs,
// FLUSH holds input while the frame goes out
`timescale 1ns/100ps
`default_nettype none

module rbg_ctrl_fsm (
    input  wire logic i_clk,
    input  wire logic i_rst_n,

    input  wire logic i_hdr_valid,
    input  wire logic i_re_valid,
    input  wire logic i_re_eop,
    input  wire logic i_rbg_last,
    input  wire logic i_flush_done,

    output logic      o_take,
    output logic      o_accum_en,
    output logic      o_accum_clr,
    output logic      o_cnt_step,
    output logic      o_cnt_rst,
    output logic      o_flush_valid
);

    dr_core_pkg::ctrl_state_e state_q, state_d;
    logic                     eop_q;            // frame being flushed ends the packet

    always_comb begin
        state_d       = state_q;
        o_take        = 1'b0;
        o_accum_en    = 1'b0;
        o_accum_clr   = 1'b0;
        o_cnt_step    = 1'b0;
        o_cnt_rst     = 1'b0;
        o_flush_valid = 1'b0;
        case (state_q)
            dr_core_pkg::ST_IDLE: begin
                o_take = 1'b1;                  // stray RE beats are dropped here
                if (i_hdr_valid) begin
                    o_cnt_rst   = 1'b1;
                    o_accum_clr = 1'b1;
                    state_d     = dr_core_pkg::ST_ACCUM;
                end
            end
            dr_core_pkg::ST_ACCUM: begin
                o_take = 1'b1;
                if (i_re_valid) begin
                    o_accum_en = 1'b1;
                    // closing RE holds the count so the rbg index stays put for the frame
                    o_cnt_step = ~i_rbg_last;
                    if (i_rbg_last || i_re_eop) begin
                        state_d = dr_core_pkg::ST_FLUSH;
                    end
                end
            end
            dr_core_pkg::ST_FLUSH: begin
                o_flush_valid = 1'b1;
                if (i_flush_done) begin
                    o_accum_clr = 1'b1;
                    o_cnt_step  = ~eop_q;       // advance to next group
                    o_cnt_rst   = eop_q;
                    state_d     = eop_q ? dr_core_pkg::ST_IDLE : dr_core_pkg::ST_ACCUM;
                end
            end
            default: state_d = dr_core_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= dr_core_pkg::ST_IDLE;
            eop_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == dr_core_pkg::ST_ACCUM && i_re_valid) begin
                eop_q <= i_re_eop;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rx_unpack.sv
// Rx beat unpacker
// header register loaded from lane 0 of the sop beat
// RE beats split into per-antenna IQ samples
`timescale 1ns/100ps
`default_nettype none

`include "pusch_dr_config.svh"

module rx_unpack (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,

    input  wire cpri_frame_pkg::rx_beat_t i_beat,
    input  wire logic                    i_valid,
    output logic                         o_ready,
    input  wire logic                    i_take,    // fsm accepts the beat

    output cpri_frame_pkg::rx_hdr_t      o_hdr,
    output logic                         o_hdr_valid,
    output dr_core_pkg::ant_iq_t         o_re,
    output logic                         o_re_valid,
    output logic                         o_re_eop
);

    cpri_frame_pkg::rx_hdr_t hdr_q;

    assign o_ready     = i_take;
    assign o_hdr       = hdr_q;
    assign o_hdr_valid = i_valid & i_beat.sop;
    assign o_re_valid  = i_valid & ~i_beat.sop;
    assign o_re_eop    = i_beat.eop;

    // lane k: antenna 2k in the low half, 2k+1 in the high half
    always_comb begin
        for (int k = 0; k < `PUSCH_LANE; k++) begin
            o_re[2*k]   = i_beat.lane[k][31:0];
            o_re[2*k+1] = i_beat.lane[k][63:32];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hdr_q <= '0;
        end else if (i_valid && i_beat.sop && i_take) begin
            hdr_q <= i_beat.lane[0];            // header lives in lane 0
        end
    end

endmodule

`default_nettype wire

// File: rtl/pipe_stage.sv
// Single-entry valid/ready register slice
// payload type is a parameter, full throughput
`timescale 1ns/100ps
`default_nettype none

module pipe_stage #(
    parameter type T = logic [63:0]
)(
    input  wire logic i_clk,
    input  wire logic i_rst_n,

    input  wire T     i_data,
    input  wire logic i_valid,
    output logic      o_ready,

    output T          o_data,
    output logic      o_valid,
    input  wire logic i_ready
);

    logic valid_q;
    T     data_q;

    assign o_ready = ~valid_q | i_ready;        // empty, or draining this cycle
    assign o_valid = valid_q;
    assign o_data  = data_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid && o_ready) begin
            data_q <= i_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dr_core_pkg.sv
// Core datapath and control types
// per-antenna IQ sample, one RE across all antennas
// power sum vector, RBG size code, control FSM state
`default_nettype none

`include "pusch_dr_config.svh"

package dr_core_pkg;

    typedef struct packed {
        logic signed [`PUSCH_IQ_W-1:0] i;       // upper half
        logic signed [`PUSCH_IQ_W-1:0] q;       // lower half
    } iq_t;

    typedef iq_t [`PUSCH_ANT-1:0] ant_iq_t;

    typedef logic [`PUSCH_ANT-1:0][`PUSCH_PWR_W-1:0] pwr_vec_t;

    typedef enum logic [1:0] {
        RBG_4   = 2'd0,
        RBG_8   = 2'd1,
        RBG_16  = 2'd2,
        RBG_16B = 2'd3                          // same length as code 2
    } rbg_size_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ACCUM = 2'd1,
        ST_FLUSH = 2'd2
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/cpri_frame_pkg.sv
// Fronthaul framing types
// rx beat with lane words and sop/eop markers
// rx header carried in lane 0 of the sop beat
// tx header word and tx stream word
`default_nettype none

`include "pusch_dr_config.svh"

package cpri_frame_pkg;

    // ----------------------------------------------------------
    // rx side
    // ----------------------------------------------------------
    typedef struct packed {
        logic [3:0]  pkg_type;
        logic        cell_idx;
        logic [6:0]  slot_idx;
        logic [3:0]  symb_idx;
        logic [7:0]  fft_agc;
        logic [39:0] pad;                       // unused, zero
    } rx_hdr_t;

    typedef struct packed {
        logic [`PUSCH_LANE-1:0][`PUSCH_WORD_W-1:0] lane;
        logic                                      sop;    // header beat
        logic                                      eop;    // last RE beat
    } rx_beat_t;

    // ----------------------------------------------------------
    // tx side
    // ----------------------------------------------------------
    typedef struct packed {
        logic [1:0]  aiu_idx;
        logic [3:0]  pkg_type;
        logic        cell_idx;
        logic [6:0]  slot_idx;
        logic [3:0]  symb_idx;
        logic [3:0]  rbg_idx;
        logic [7:0]  fft_agc;
        logic [33:0] pad;                       // fills the lsbs
    } tx_hdr_t;

    typedef logic [`PUSCH_WORD_W-1:0] tx_word_t;

endpackage

`default_nettype wire

// File: rtl/pusch_dr_config.svh
// Build-time configuration for the PUSCH power front end
// lane count, antenna count, sample and word widths
// RBG lengths selected by the size code
`ifndef PUSCH_DR_CONFIG_SVH
`define PUSCH_DR_CONFIG_SVH

// ----------------------------------------------------------
// fronthaul geometry
// ----------------------------------------------------------
`define PUSCH_LANE      4                   // 64-bit lanes per beat
`define PUSCH_ANT       (2 * `PUSCH_LANE)   // two antennas per lane
`define PUSCH_IQ_W      16                  // width of I and of Q
`define PUSCH_WORD_W    64                  // lane and tx word width

// ----------------------------------------------------------
// power and RBG grouping
// ----------------------------------------------------------
`define PUSCH_PWR_W     40                  // accumulated power width
`define PUSCH_RBG_IDX_W 4                   // rbg index wraps mod 16
`define PUSCH_RBG_LEN_0 4                   // size code 0
`define PUSCH_RBG_LEN_1 8                   // size code 1
`define PUSCH_RBG_LEN_2 16                  // size codes 2 and 3

`endif
